// File: Makefile
# Verilator build and regression for the vector memop bridge

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the regression"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

obj_dir/Vtb_ovi: filelist.f $(wildcard *.sv)
	verilator --binary --timing --assert --timescale 1ns/1ps --top-module tb_ovi -f filelist.f

test: obj_dir/Vtb_ovi
	@out="$$(./obj_dir/Vtb_ovi)"; echo "$$out"; echo "$$out" | grep -q "Regression passed"

clean:
	rm -rf obj_dir

// File: filelist.f
ovi_pkg.sv
ovi_issue_queue.sv
ovi_seq_ctrl.sv
ovi_load_unit.sv
ovi_store_unit.sv
ovi_vreg_arbiter.sv
ovi_top.sv
tb_ovi.sv

// File: ovi_issue_queue.sv
/*
  Issue FIFO between the core and the sequencer.
  No full check: the core issues only while it holds a credit.
  A pop must only be raised while the head is valid.
*/
`timescale 1ns/1ps
`default_nettype none

module ovi_issue_queue (
  input  logic                          clk,
  input  logic                          reset_n,
  input  logic                          i_issue_valid,
  input  logic [ovi_pkg::INST_W-1:0]    i_issue_inst,
  input  logic [ovi_pkg::SB_ID_W-1:0]   i_issue_sb_id,
  input  logic [ovi_pkg::SCALAR_W-1:0]  i_issue_scalar_opnd,
  input  logic                          i_pop,
  output logic                          o_issue_credit,
  output logic                          o_head_valid,
  output logic [ovi_pkg::INST_W-1:0]    o_head_inst,
  output logic [ovi_pkg::SB_ID_W-1:0]   o_head_sb_id,
  output logic [ovi_pkg::SCALAR_W-1:0]  o_head_scalar_opnd
);
  import ovi_pkg::*;

  localparam int PTR_W = $clog2(ISSUE_DEPTH);

  logic [INST_W-1:0]   inst_mem  [ISSUE_DEPTH];
  logic [SB_ID_W-1:0]  sb_id_mem [ISSUE_DEPTH];
  logic [SCALAR_W-1:0] opnd_mem  [ISSUE_DEPTH];
  logic [PTR_W-1:0]    wr_ptr;
  logic [PTR_W-1:0]    rd_ptr;
  logic [PTR_W:0]      count;
  logic                pop_ok;

  assign o_head_valid       = count != '0;
  assign o_head_inst        = inst_mem[rd_ptr];
  assign o_head_sb_id       = sb_id_mem[rd_ptr];
  assign o_head_scalar_opnd = opnd_mem[rd_ptr];
  assign pop_ok             = i_pop && o_head_valid;

  // one credit goes back with every entry that leaves
  assign o_issue_credit = pop_ok;

  always_ff @(posedge clk) begin
    if (i_issue_valid) begin
      inst_mem[wr_ptr]  <= i_issue_inst;
      sb_id_mem[wr_ptr] <= i_issue_sb_id;
      opnd_mem[wr_ptr]  <= i_issue_scalar_opnd;
    end
  end

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (i_issue_valid) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop_ok) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({i_issue_valid, pop_ok})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: ovi_load_unit.sv
/*
  Unpacks load beats into masked register writes, one cycle after arrival.
  Strides of +1, -1 and +2 elements only; other beats are dropped.
  Only the low VLEN bits of the packed beat can reach a register.
*/
`timescale 1ns/1ps
`default_nettype none

module ovi_load_unit (
  input  logic                            clk,
  input  logic                            reset_n,
  input  logic                            i_load_active,
  input  logic [1:0]                      i_eew,
  input  logic [ovi_pkg::SCALAR_W-1:0]    i_stride,
  input  logic                            i_load_valid,
  input  logic [ovi_pkg::BEAT_W-1:0]      i_load_data,
  input  logic [ovi_pkg::SEQ_ID_W-1:0]    i_load_seq_id,
  output logic                            o_wr_req,
  output logic [ovi_pkg::VREG_IDX_W-1:0]  o_wr_idx,
  output logic [ovi_pkg::VLEN-1:0]        o_wr_data,
  output logic [ovi_pkg::VLEN-1:0]        o_wr_mask
);
  import ovi_pkg::*;

  localparam int SH_W = $clog2(VLEN);

  beat_u               bt;
  beat_u               pk;
  logic [SCALAR_W-1:0] esz;
  logic                unit;
  logic                rev;
  logic                two;
  logic                el_off0;
  logic [10:0]         el_id;
  logic [6:0]          el_count;
  logic [18:0]         lo_bit;
  logic [18:0]         hi_bit;
  logic [18:0]         sh_full;
  logic [2*VLEN-1:0]   rot2;
  logic [VLEN-1:0]     rot_data;
  logic [VLEN-1:0]     mask;

  assign bt       = i_load_data;
  assign el_id    = i_load_seq_id[SEQ_ELID_MSB:SEQ_ELID_LSB];
  assign el_off0  = i_load_seq_id[SEQ_ELOFF_LSB];
  assign el_count = i_load_seq_id[SEQ_ELCNT_MSB:SEQ_ELCNT_LSB];

  // stride is in bytes, compare against the element size
  assign esz  = SCALAR_W'(1) << i_eew;
  assign unit = i_stride == esz;
  assign rev  = i_stride == -esz;
  assign two  = i_stride == (esz << 1);

  // source element for packed element i out of n
  function automatic int src_index(input int i, input int n, input logic r, input logic t,
                                   input logic off);
    if (r) begin
      return n - 1 - i;
    end
    if (t) begin
      return 2 * i + int'(off);
    end
    return i;
  endfunction

  always_comb begin
    int src;
    pk = '0;
    case (i_eew)
      2'd0: begin
        for (int i = 0; i < BEAT_W / 8; i++) begin
          src = src_index(i, BEAT_W / 8, rev, two, el_off0);
          if (src < BEAT_W / 8) pk.e8[i] = bt.e8[src];
        end
      end
      2'd1: begin
        for (int i = 0; i < BEAT_W / 16; i++) begin
          src = src_index(i, BEAT_W / 16, rev, two, el_off0);
          if (src < BEAT_W / 16) pk.e16[i] = bt.e16[src];
        end
      end
      2'd2: begin
        for (int i = 0; i < BEAT_W / 32; i++) begin
          src = src_index(i, BEAT_W / 32, rev, two, el_off0);
          if (src < BEAT_W / 32) pk.e32[i] = bt.e32[src];
        end
      end
      default: begin
        for (int i = 0; i < BEAT_W / 64; i++) begin
          src = src_index(i, BEAT_W / 64, rev, two, el_off0);
          if (src < BEAT_W / 64) pk.e64[i] = bt.e64[src];
        end
      end
    endcase
  end

  // rotate packed element 0 up to el_id, window in bits
  assign sh_full  = 19'(el_id) << (3'(i_eew) + 3'd3);
  assign rot2     = {pk[VLEN-1:0], pk[VLEN-1:0]} << sh_full[SH_W-1:0];
  assign rot_data = rot2[2*VLEN-1 -: VLEN];
  assign lo_bit   = sh_full;
  assign hi_bit   = (19'(el_id) + 19'(el_count)) << (3'(i_eew) + 3'd3);

  always_comb begin
    for (int k = 0; k < VLEN; k++) begin
      mask[k] = (19'(k) >= lo_bit) && (19'(k) < hi_bit);
    end
  end

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      o_wr_req <= 1'b0;
    end else begin
      o_wr_req <= i_load_valid && i_load_active && (unit || rev || two);
    end
  end

  always_ff @(posedge clk) begin
    o_wr_idx  <= i_load_seq_id[SEQ_VREG_LSB +: VREG_IDX_W];
    o_wr_data <= rot_data;
    o_wr_mask <= mask;
  end

endmodule

`default_nettype wire

// File: ovi_pkg.sv
/*
  Shared widths, opcodes and the load beat view for the vector memop bridge.
  VLEN must stay at or below half of BEAT_W because a store uses only the low half.
  The seq-id field positions follow the load tag layout of the memory system.
*/
`default_nettype none

package ovi_pkg;

  localparam int VLEN          = 256;
  localparam int NUM_VREGS     = 8;
  localparam int VREG_IDX_W    = 3;
  localparam int BEAT_W        = 512;
  localparam int ISSUE_DEPTH   = 16;
  localparam int STORE_CREDITS = 4;
  localparam int SB_ID_W       = 5;
  localparam int INST_W        = 32;
  localparam int SCALAR_W      = 64;
  localparam int SEQ_ID_W      = 34;

  // major opcodes
  localparam logic [6:0] OPC_VLOAD  = 7'b0000111;
  localparam logic [6:0] OPC_VSTORE = 7'b0100111;

  // width field codes of vector loads and stores
  localparam logic [2:0] WIDTH_E8  = 3'b000;
  localparam logic [2:0] WIDTH_E16 = 3'b101;
  localparam logic [2:0] WIDTH_E32 = 3'b110;
  localparam logic [2:0] WIDTH_E64 = 3'b111;

  // load seq-id fields
  localparam int SEQ_VREG_LSB  = 0;
  localparam int SEQ_VREG_MSB  = 4;
  localparam int SEQ_ELID_LSB  = 5;
  localparam int SEQ_ELID_MSB  = 15;
  localparam int SEQ_ELOFF_LSB = 16;
  localparam int SEQ_ELOFF_MSB = 21;
  localparam int SEQ_ELCNT_LSB = 22;
  localparam int SEQ_ELCNT_MSB = 28;
  localparam int SEQ_SBID_LSB  = 29;
  localparam int SEQ_SBID_MSB  = 33;

  // sequencer states
  localparam logic [1:0] ST_IDLE       = 2'd0;
  localparam logic [1:0] ST_LOAD_WAIT  = 2'd1;
  localparam logic [1:0] ST_STORE_WAIT = 2'd2;
  localparam logic [1:0] ST_COMMIT     = 2'd3;

  // one load beat, seen at each element width
  typedef union packed {
    logic [BEAT_W/8-1:0][7:0]   e8;
    logic [BEAT_W/16-1:0][15:0] e16;
    logic [BEAT_W/32-1:0][31:0] e32;
    logic [BEAT_W/64-1:0][63:0] e64;
  } beat_u;

endpackage

`default_nettype wire

// File: ovi_seq_ctrl.sv
/*
  Runs one instruction at a time in issue order.
  Only vector loads and stores at widths 8, 16, 32 and 64 are legal;
  anything else completes at once with the illegal flag set.
*/
`timescale 1ns/1ps
`default_nettype none

module ovi_seq_ctrl (
  input  logic                            clk,
  input  logic                            reset_n,
  input  logic                            i_head_valid,
  input  logic [ovi_pkg::INST_W-1:0]      i_head_inst,
  input  logic [ovi_pkg::SB_ID_W-1:0]     i_head_sb_id,
  input  logic [ovi_pkg::SCALAR_W-1:0]    i_head_scalar_opnd,
  input  logic                            i_memop_sync_end,
  input  logic                            i_store_sent,
  output logic                            o_pop,
  output logic                            o_memop_sync_start,
  output logic                            o_load_active,
  output logic [1:0]                      o_eew,
  output logic [ovi_pkg::SCALAR_W-1:0]    o_stride,
  output logic                            o_store_start,
  output logic [ovi_pkg::VREG_IDX_W-1:0]  o_store_idx,
  output logic                            o_completed_valid,
  output logic [ovi_pkg::SB_ID_W-1:0]     o_completed_sb_id,
  output logic                            o_completed_illegal,
  output logic [ovi_pkg::SCALAR_W-1:0]    o_completed_dest_reg
);
  import ovi_pkg::*;

  logic [1:0] state;
  logic [6:0] opcode;
  logic [2:0] wcode;
  logic       vec_width;
  logic       is_load;
  logic       is_store;
  logic       sent_seen;
  logic       end_seen;
  logic       store_done;
  logic       take;

  assign opcode     = i_head_inst[6:0];
  assign wcode      = i_head_inst[14:12];
  assign vec_width  = wcode inside {WIDTH_E8, WIDTH_E16, WIDTH_E32, WIDTH_E64};
  assign is_load    = (opcode == OPC_VLOAD) && vec_width;
  assign is_store   = (opcode == OPC_VSTORE) && vec_width;
  assign take       = (state == ST_IDLE) && o_pop;
  // a store needs both its beat out and the sync end, in either order
  assign store_done = (sent_seen || i_store_sent) && (end_seen || i_memop_sync_end);

  assign o_load_active        = state == ST_LOAD_WAIT;
  assign o_completed_valid    = state == ST_COMMIT;
  assign o_completed_dest_reg = '0;

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      state              <= ST_IDLE;
      o_pop              <= 1'b0;
      o_memop_sync_start <= 1'b0;
      o_store_start      <= 1'b0;
      sent_seen          <= 1'b0;
      end_seen           <= 1'b0;
    end else begin
      o_pop              <= 1'b0;
      o_memop_sync_start <= 1'b0;
      o_store_start      <= 1'b0;
      case (state)
        ST_IDLE: begin
          if (o_pop) begin
            o_memop_sync_start <= is_load || is_store;
            o_store_start      <= is_store;
            state <= is_load ? ST_LOAD_WAIT : (is_store ? ST_STORE_WAIT : ST_COMMIT);
          end else begin
            o_pop <= i_head_valid;
          end
        end
        ST_LOAD_WAIT: begin
          if (i_memop_sync_end) begin
            state <= ST_COMMIT;
          end
        end
        ST_STORE_WAIT: begin
          sent_seen <= sent_seen || i_store_sent;
          end_seen  <= end_seen || i_memop_sync_end;
          if (store_done) begin
            state     <= ST_COMMIT;
            sent_seen <= 1'b0;
            end_seen  <= 1'b0;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // operation fields held for the whole run
  always_ff @(posedge clk) begin
    if (take) begin
      o_stride            <= i_head_scalar_opnd;
      o_store_idx         <= i_head_inst[7 +: VREG_IDX_W];
      o_completed_sb_id   <= i_head_sb_id;
      o_completed_illegal <= !(is_load || is_store);
      case (wcode)
        WIDTH_E16: o_eew <= 2'd1;
        WIDTH_E32: o_eew <= 2'd2;
        WIDTH_E64: o_eew <= 2'd3;
        default:   o_eew <= 2'd0;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: ovi_store_unit.sv
/*
  Reads one register and sends it as a single store beat.
  The register sits in the low half of the beat, the upper half is zero.
  A new store_start must not arrive before store_sent of the previous one.
*/
`timescale 1ns/1ps
`default_nettype none

module ovi_store_unit (
  input  logic                            clk,
  input  logic                            reset_n,
  input  logic                            i_store_start,
  input  logic [ovi_pkg::VREG_IDX_W-1:0]  i_store_idx,
  input  logic                            i_rd_grant,
  input  logic [ovi_pkg::VLEN-1:0]        i_rd_data,
  input  logic                            i_store_credit,
  output logic                            o_rd_req,
  output logic [ovi_pkg::VREG_IDX_W-1:0]  o_rd_idx,
  output logic                            o_store_valid,
  output logic [ovi_pkg::BEAT_W-1:0]      o_store_data,
  output logic                            o_store_sent
);
  import ovi_pkg::*;

  logic [$clog2(STORE_CREDITS):0] credits;
  logic                           data_pend;
  logic                           send_pend;
  logic                           send;

  assign send         = send_pend && (credits != '0);
  assign o_store_sent = o_store_valid;

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      credits       <= STORE_CREDITS[$clog2(STORE_CREDITS):0];
      o_rd_req      <= 1'b0;
      data_pend     <= 1'b0;
      send_pend     <= 1'b0;
      o_store_valid <= 1'b0;
    end else begin
      o_store_valid <= send;
      // read data shows up one cycle after the grant
      data_pend     <= o_rd_req && i_rd_grant;
      if (i_store_start) begin
        o_rd_req <= 1'b1;
      end else if (i_rd_grant) begin
        o_rd_req <= 1'b0;
      end
      if (data_pend) begin
        send_pend <= 1'b1;
      end else if (send) begin
        send_pend <= 1'b0;
      end
      case ({i_store_credit, send})
        2'b10:   credits <= credits + 1'b1;
        2'b01:   credits <= credits - 1'b1;
        default: credits <= credits;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (i_store_start) begin
      o_rd_idx <= i_store_idx;
    end
    if (data_pend) begin
      o_store_data <= {{(BEAT_W - VLEN){1'b0}}, i_rd_data};
    end
  end

endmodule

`default_nettype wire

// File: ovi_top.sv
/*
  Vector memop bridge between the core issue port and the memory system.
  The core starts with ISSUE_DEPTH issue credits, the bridge with STORE_CREDITS.
  o_completed_dest_reg is always zero.
*/
`timescale 1ns/1ps
`default_nettype none

module ovi_top (
  input  logic                          clk,
  input  logic                          reset_n,
  input  logic                          i_issue_valid,
  input  logic [ovi_pkg::INST_W-1:0]    i_issue_inst,
  input  logic [ovi_pkg::SB_ID_W-1:0]   i_issue_sb_id,
  input  logic [ovi_pkg::SCALAR_W-1:0]  i_issue_scalar_opnd,
  output logic                          o_issue_credit,
  output logic                          o_memop_sync_start,
  input  logic                          i_memop_sync_end,
  output logic                          o_store_valid,
  output logic [ovi_pkg::BEAT_W-1:0]    o_store_data,
  input  logic                          i_store_credit,
  input  logic                          i_load_valid,
  input  logic [ovi_pkg::BEAT_W-1:0]    i_load_data,
  input  logic [ovi_pkg::SEQ_ID_W-1:0]  i_load_seq_id,
  output logic                          o_completed_valid,
  output logic [ovi_pkg::SB_ID_W-1:0]   o_completed_sb_id,
  output logic                          o_completed_illegal,
  output logic [ovi_pkg::SCALAR_W-1:0]  o_completed_dest_reg
);
  import ovi_pkg::*;

  logic                  head_valid;
  logic [INST_W-1:0]     head_inst;
  logic [SB_ID_W-1:0]    head_sb_id;
  logic [SCALAR_W-1:0]   head_scalar_opnd;
  logic                  pop;
  logic                  load_active;
  logic [1:0]            eew;
  logic [SCALAR_W-1:0]   stride;
  logic                  store_start;
  logic [VREG_IDX_W-1:0] store_idx;
  logic                  store_sent;
  logic                  wr_req;
  logic [VREG_IDX_W-1:0] wr_idx;
  logic [VLEN-1:0]       wr_data;
  logic [VLEN-1:0]       wr_mask;
  logic                  rd_req;
  logic [VREG_IDX_W-1:0] rd_idx;
  logic                  rd_grant;
  logic [VLEN-1:0]       rd_data;

  ovi_issue_queue iq0 (
    .clk, .reset_n, .i_issue_valid, .i_issue_inst, .i_issue_sb_id, .i_issue_scalar_opnd,
    .i_pop(pop), .o_issue_credit, .o_head_valid(head_valid), .o_head_inst(head_inst),
    .o_head_sb_id(head_sb_id), .o_head_scalar_opnd(head_scalar_opnd)
  );

  ovi_seq_ctrl ctrl0 (
    .clk, .reset_n, .i_head_valid(head_valid), .i_head_inst(head_inst),
    .i_head_sb_id(head_sb_id), .i_head_scalar_opnd(head_scalar_opnd), .i_memop_sync_end,
    .i_store_sent(store_sent), .o_pop(pop), .o_memop_sync_start,
    .o_load_active(load_active), .o_eew(eew), .o_stride(stride),
    .o_store_start(store_start), .o_store_idx(store_idx), .o_completed_valid,
    .o_completed_sb_id, .o_completed_illegal, .o_completed_dest_reg
  );

  ovi_load_unit ld0 (
    .clk, .reset_n, .i_load_active(load_active), .i_eew(eew), .i_stride(stride),
    .i_load_valid, .i_load_data, .i_load_seq_id, .o_wr_req(wr_req), .o_wr_idx(wr_idx),
    .o_wr_data(wr_data), .o_wr_mask(wr_mask)
  );

  ovi_store_unit st0 (
    .clk, .reset_n, .i_store_start(store_start), .i_store_idx(store_idx),
    .i_rd_grant(rd_grant), .i_rd_data(rd_data), .i_store_credit, .o_rd_req(rd_req),
    .o_rd_idx(rd_idx), .o_store_valid, .o_store_data, .o_store_sent(store_sent)
  );

  ovi_vreg_arbiter vrf0 (
    .clk, .reset_n, .i_wr_req(wr_req), .i_wr_idx(wr_idx), .i_wr_data(wr_data),
    .i_wr_mask(wr_mask), .i_rd_req(rd_req), .i_rd_idx(rd_idx), .o_rd_grant(rd_grant),
    .o_rd_data(rd_data)
  );

endmodule

`default_nettype wire

// File: ovi_vreg_arbiter.sv
/*
  Eight vector registers behind one shared port.
  A write always wins; a read is granted only in a cycle with no write
  and its data is returned one cycle after the grant.
*/
`timescale 1ns/1ps
`default_nettype none

module ovi_vreg_arbiter (
  input  logic                            clk,
  input  logic                            reset_n,
  input  logic                            i_wr_req,
  input  logic [ovi_pkg::VREG_IDX_W-1:0]  i_wr_idx,
  input  logic [ovi_pkg::VLEN-1:0]        i_wr_data,
  input  logic [ovi_pkg::VLEN-1:0]        i_wr_mask,
  input  logic                            i_rd_req,
  input  logic [ovi_pkg::VREG_IDX_W-1:0]  i_rd_idx,
  output logic                            o_rd_grant,
  output logic [ovi_pkg::VLEN-1:0]        o_rd_data
);
  import ovi_pkg::*;

  logic [VLEN-1:0] vregs [NUM_VREGS];

  assign o_rd_grant = i_rd_req && !i_wr_req;

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      for (int r = 0; r < NUM_VREGS; r++) begin
        vregs[r] <= '0;
      end
    end else if (i_wr_req) begin
      // merge under the element window only
      vregs[i_wr_idx] <= (vregs[i_wr_idx] & ~i_wr_mask) | (i_wr_data & i_wr_mask);
    end
  end

  always_ff @(posedge clk) begin
    if (o_rd_grant) begin
      o_rd_data <= vregs[i_rd_idx];
    end
  end

endmodule

`default_nettype wire

// File: tb_ovi.sv
/*
  Self-checking testbench for the vector memop bridge.
  Every load carries one beat. The memory side answers each sync start by itself.
  Store credits come back automatically unless credit_hold is set.
*/
`timescale 1ns/1ps
`default_nettype none

module tb_ovi;
  import ovi_pkg::*;

  localparam int MAX_CYCLES = 4000;

  logic                clk;
  logic                reset_n;
  logic                i_issue_valid;
  logic [INST_W-1:0]   i_issue_inst;
  logic [SB_ID_W-1:0]  i_issue_sb_id;
  logic [SCALAR_W-1:0] i_issue_scalar_opnd;
  logic                i_memop_sync_end;
  logic                i_store_credit;
  logic                i_load_valid;
  logic [BEAT_W-1:0]   i_load_data;
  logic [SEQ_ID_W-1:0] i_load_seq_id;
  logic                o_issue_credit;
  logic                o_memop_sync_start;
  logic                o_store_valid;
  logic [BEAT_W-1:0]   o_store_data;
  logic                o_completed_valid;
  logic [SB_ID_W-1:0]  o_completed_sb_id;
  logic                o_completed_illegal;
  logic [SCALAR_W-1:0] o_completed_dest_reg;

  // reference model of the register store and expected responses
  logic [VLEN-1:0]     vmodel [NUM_VREGS];
  logic [SB_ID_W-1:0]  next_sb = '0;
  logic [SB_ID_W-1:0]  exp_sb_q [$];
  logic                exp_ill_q [$];
  logic [BEAT_W-1:0]   exp_store_q [$];
  // 1 for a load, 0 for a store
  logic                kind_q [$];
  logic [BEAT_W-1:0]   beat_q [$];
  logic [SEQ_ID_W-1:0] seq_q [$];
  int                  seed;
  int                  cycle;
  int                  issued;
  int                  credits_back;
  int                  st_beats;
  int                  st_credits_given;
  int                  credit_paid;
  logic                credit_hold = 1'b0;
  logic                sync_open = 1'b0;
  string               test_name;

  ovi_top dut0 (.*);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("Regression failed");
  endtask

  initial begin
    wait (cycle >= MAX_CYCLES);
    fail_run($sformatf("timeout: the run did not finish within %0d cycles", MAX_CYCLES));
    $fatal(1);
  end

  // no control output may move during reset
  assert property (@(posedge clk) (!reset_n && cycle > 0) |->
      !(o_issue_credit || o_memop_sync_start || o_store_valid || o_completed_valid))
    else begin
      fail_run("reset_state: a control output was active during reset");
      $fatal(1);
    end

  assert property (@(posedge clk) disable iff (!reset_n) o_issue_credit |-> credits_back < issued)
    else begin
      fail_run($sformatf("** Error %s: issue credits expected at most %0d actual %0d",
                         test_name, issued, credits_back + 1));
      $fatal(1);
    end

  assert property (@(posedge clk) disable iff (!reset_n)
      o_store_valid |-> st_beats < STORE_CREDITS + st_credits_given)
    else begin
      fail_run($sformatf("** Error %s: store beats expected at most %0d actual %0d",
                         test_name, STORE_CREDITS + st_credits_given, st_beats + 1));
      $fatal(1);
    end

  assert property (@(posedge clk) disable iff (!reset_n) o_memop_sync_start |-> !sync_open)
    else begin
      fail_run($sformatf("** Error %s: sync starts per operation expected 1 actual 2",
                         test_name));
      $fatal(1);
    end

  // response monitor
  always @(posedge clk) begin
    logic [BEAT_W-1:0]  exp_beat;
    logic [SB_ID_W-1:0] exp_sb;
    logic               exp_ill;
    cycle <= cycle + 1;
    if (reset_n) begin
      if (o_issue_credit) credits_back <= credits_back + 1;
      if (i_store_credit) st_credits_given <= st_credits_given + 1;
      if (o_memop_sync_start) sync_open <= 1'b1;
      if (o_store_valid) begin
        st_beats <= st_beats + 1;
        exp_beat = exp_store_q.size() != 0 ? exp_store_q.pop_front() : 'x;
        assert (o_store_data === exp_beat) else begin
          fail_run($sformatf("** Error %s: store data expected %h actual %h",
                             test_name, exp_beat, o_store_data));
          $fatal(1);
        end
      end
      if (o_completed_valid) begin
        exp_sb  = exp_sb_q.size() != 0 ? exp_sb_q.pop_front() : 'x;
        exp_ill = exp_ill_q.size() != 0 ? exp_ill_q.pop_front() : 1'bx;
        assert (o_completed_sb_id === exp_sb) else begin
          fail_run($sformatf("** Error %s: completion sb_id expected %0d actual %0d",
                             test_name, exp_sb, o_completed_sb_id));
          $fatal(1);
        end
        assert (o_completed_illegal === exp_ill) else begin
          fail_run($sformatf("** Error %s: illegal flag expected %0b actual %0b",
                             test_name, exp_ill, o_completed_illegal));
          $fatal(1);
        end
        assert (sync_open === !exp_ill) else begin
          fail_run($sformatf("** Error %s: sync starts before completion expected %0d actual %0d",
                             test_name, !exp_ill, sync_open));
          $fatal(1);
        end
        assert (o_completed_dest_reg == '0) else begin
          fail_run($sformatf("** Error %s: dest_reg expected 0 actual %h",
                             test_name, o_completed_dest_reg));
          $fatal(1);
        end
        sync_open <= 1'b0;
      end
    end
  end

  // memory side, one beat per load and a sync end for every operation
  initial begin
    i_memop_sync_end = 1'b0;
    i_load_valid     = 1'b0;
    i_load_data      = '0;
    i_load_seq_id    = '0;
    forever begin
      @(posedge clk);
      if (reset_n && o_memop_sync_start) begin
        if (kind_q.size() == 0) begin
          fail_run("memory side: sync start with no load or store pending");
          $fatal(1);
        end else begin
          if (kind_q.pop_front()) begin
            @(negedge clk);
            i_load_valid  = 1'b1;
            i_load_data   = beat_q.pop_front();
            i_load_seq_id = seq_q.pop_front();
            @(negedge clk);
            i_load_valid = 1'b0;
            @(negedge clk);
          end else begin
            repeat (2) @(negedge clk);
          end
          i_memop_sync_end = 1'b1;
          @(negedge clk);
          i_memop_sync_end = 1'b0;
        end
      end
    end
  end

  // store credit return, one per cycle
  initial begin
    i_store_credit = 1'b0;
    forever begin
      @(negedge clk);
      i_store_credit = 1'b0;
      if (!credit_hold && credit_paid < st_beats) begin
        i_store_credit = 1'b1;
        credit_paid++;
      end
    end
  end

  function automatic logic [2:0] width_code(input int eew);
    case (eew)
      0:       return WIDTH_E8;
      1:       return WIDTH_E16;
      2:       return WIDTH_E32;
      default: return WIDTH_E64;
    endcase
  endfunction

  function automatic logic [INST_W-1:0] make_inst(input logic [6:0] opc, input logic [2:0] w,
                                                  input int vreg);
    return {17'b0, w, 5'(vreg), opc};
  endfunction

  function automatic logic [BEAT_W-1:0] random_beat();
    logic [BEAT_W-1:0] b;
    for (int j = 0; j < BEAT_W / 32; j++) begin
      b[j*32 +: 32] = $random(seed);
    end
    return b;
  endfunction

  // issue only while a credit is held, called on a falling edge
  task automatic issue(input logic [INST_W-1:0] inst, input logic [SCALAR_W-1:0] opnd,
                       input logic illegal);
    while (ISSUE_DEPTH - issued + credits_back <= 0) @(negedge clk);
    exp_sb_q.push_back(next_sb);
    exp_ill_q.push_back(illegal);
    i_issue_valid       = 1'b1;
    i_issue_inst        = inst;
    i_issue_sb_id       = next_sb;
    i_issue_scalar_opnd = opnd;
    issued++;
    next_sb++;
    @(negedge clk);
    i_issue_valid = 1'b0;
  endtask

  // kind 0 is +1 element, 1 is -1 element, 2 is +2 elements
  task automatic load_op(input int vreg, input int eew, input int kind, input int off,
                         input int el_id, input int el_count);
    int                  esz;
    int                  n_reg;
    int                  n_beat;
    int                  src;
    logic [BEAT_W-1:0]   beat;
    logic [SCALAR_W-1:0] stride;
    logic [SEQ_ID_W-1:0] seq;
    esz    = 1 << eew;
    n_reg  = VLEN / 8 / esz;
    n_beat = BEAT_W / 8 / esz;
    beat   = random_beat();
    case (kind)
      0:       stride = SCALAR_W'(esz);
      1:       stride = -SCALAR_W'(esz);
      default: stride = SCALAR_W'(2 * esz);
    endcase
    seq = {next_sb, 7'(el_count), 6'(off), 11'(el_id), 5'(vreg)};
    // window element k takes packed element k - el_id
    for (int k = el_id; k < el_id + el_count && k < n_reg; k++) begin
      case (kind)
        0:       src = k - el_id;
        1:       src = n_beat - 1 - (k - el_id);
        default: src = 2 * (k - el_id) + off;
      endcase
      for (int b = 0; b < esz; b++) begin
        vmodel[vreg][(k*esz+b)*8 +: 8] = beat[(src*esz+b)*8 +: 8];
      end
    end
    kind_q.push_back(1'b1);
    beat_q.push_back(beat);
    seq_q.push_back(seq);
    issue(make_inst(OPC_VLOAD, width_code(eew), vreg), stride, 1'b0);
  endtask

  task automatic store_op(input int vreg);
    exp_store_q.push_back({{(BEAT_W - VLEN){1'b0}}, vmodel[vreg]});
    kind_q.push_back(1'b0);
    issue(make_inst(OPC_VSTORE, WIDTH_E64, vreg), '0, 1'b0);
  endtask

  task automatic wait_idle();
    while (exp_sb_q.size() != 0 || credit_paid != st_beats) @(negedge clk);
    repeat (3) @(negedge clk);
  endtask

  initial begin
    int base;
    int n;
    seed                = 33320;
    reset_n             = 1'b0;
    i_issue_valid       = 1'b0;
    i_issue_inst        = '0;
    i_issue_sb_id       = '0;
    i_issue_scalar_opnd = '0;
    for (int r = 0; r < NUM_VREGS; r++) begin
      vmodel[r] = '0;
    end
    test_name = "reset";
    repeat (3) @(posedge clk);
    @(negedge clk);
    reset_n = 1'b1;
    repeat (2) @(negedge clk);

    test_name = "unit_stride";
    for (int e = 0; e < 4; e++) begin
      load_op(e, e, 0, 0, 0, (VLEN / 8) >> e);
      store_op(e);
    end
    wait_idle();

    test_name = "reverse";
    for (int e = 0; e < 4; e++) begin
      load_op(e + 4, e, 1, 0, 0, (VLEN / 8) >> e);
      store_op(e + 4);
    end
    wait_idle();

    // fresh base, then a partial window, the second one clipped at the top
    test_name = "stride_two";
    for (int e = 0; e < 4; e++) begin
      n = (VLEN / 8) >> e;
      for (int off = 0; off < 2; off++) begin
        load_op(2, e, 0, 0, 0, n);
        load_op(2, e, 2, off, off ? n - 2 : 1, off ? 4 : n / 2);
        store_op(2);
      end
    end
    wait_idle();

    test_name = "store_credits";
    credit_hold = 1'b1;
    base        = st_beats;
    for (int i = 0; i < STORE_CREDITS + 1; i++) begin
      store_op(i);
    end
    while (st_beats < base + STORE_CREDITS) @(negedge clk);
    repeat (20) @(negedge clk);
    assert (st_beats == base + STORE_CREDITS && exp_sb_q.size() == 1) else begin
      fail_run($sformatf("** Error %s: expected %0d beats and 1 open store, actual %0d and %0d",
                         test_name, base + STORE_CREDITS, st_beats, exp_sb_q.size()));
      $fatal(1);
    end
    credit_hold = 1'b0;
    wait_idle();

    test_name = "illegal_order";
    issue(make_inst(7'b0110011, 3'b000, 1), '0, 1'b1);
    load_op(6, 2, 0, 0, 2, 3);
    issue(make_inst(OPC_VLOAD, 3'b001, 1), '0, 1'b1);
    issue(make_inst(OPC_VSTORE, 3'b010, 6), '0, 1'b1);
    store_op(6);
    wait_idle();

    test_name = "issue_burst";
    for (int i = 0; i < ISSUE_DEPTH; i++) begin
      case (i % 4)
        0:       store_op(i % 8);
        1:       issue(make_inst(7'b1010111, 3'b000, i % 8), '0, 1'b1);
        2:       load_op(i % 8, (i / 4) % 4, 0, 0, 0, (VLEN / 8) >> ((i / 4) % 4));
        default: load_op(i % 8, (i / 4) % 4, 1, 0, 0, (VLEN / 8) >> ((i / 4) % 4));
      endcase
    end
    wait_idle();

    if (credits_back == issued) begin
      $display("Regression passed");
      $finish;
    end else begin
      fail_run($sformatf("** Error %s: issue credits returned expected %0d actual %0d",
                         test_name, issued, credits_back));
      $fatal(1);
    end
  end

endmodule

`default_nettype wire
